/* hw/trace_params_pkg.sv */
/*
 * trace sizing constants
 * widths of the branch map, the branch count and instruction addresses
 */
package trace_params_pkg;

    // outcome bits held by one branch map
    localparam int BRANCH_MAP_LEN = 31;

    // count runs 0..31, so five bits
    localparam int BRANCH_COUNT_LEN = 5;

    // instruction address width
    localparam int IADDR_LEN = 32;

endpackage

/* hw/trace_types_pkg.sv */
/*
 * trace encoder types
 * retired instruction kinds and trace packet formats
 */
package trace_types_pkg;

    // kind of instruction reported by the retirement port
    typedef enum logic [2:0] {
        ITYPE_OTHER            = 3'd0,
        ITYPE_BRANCH_TAKEN     = 3'd1,
        ITYPE_BRANCH_NOT_TAKEN = 3'd2,
        ITYPE_JUMP_UNINF       = 3'd3,
        ITYPE_EXCEPTION        = 3'd4
    } itype_e;

    // branch-history packet formats
    typedef enum logic [1:0] {
        FMT_BRANCH_FULL = 2'd0,  // full map, no address
        FMT_BRANCH_ADDR = 2'd1,  // map plus address
        FMT_ADDR_ONLY   = 2'd2   // address only, map was empty
    } pkt_fmt_e;

endpackage

/* hw/instr_classifier.sv */
/*
 * instruction classifier
 * turns retirement reports into branch strobes and packet requests
 */
module instr_classifier
    import trace_params_pkg::*, trace_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 retire_valid_i,
    input  itype_e               itype_i,
    input  logic [IADDR_LEN-1:0] iaddr_i,
    output logic                 branch_valid_o,
    output logic                 branch_taken_o,
    output logic                 packet_req_o,
    output logic [IADDR_LEN-1:0] req_addr_o
);

    // first stage holds the raw report
    logic                 ret_valid_q;
    itype_e               itype_q;
    logic [IADDR_LEN-1:0] iaddr_q;

    // decoded kind of the held report
    logic is_branch;
    logic is_req;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ret_valid_q <= 1'b0;
        end else begin
            ret_valid_q <= retire_valid_i;
        end
        itype_q <= itype_i;
        iaddr_q <= iaddr_i;
    end

    // ITYPE_OTHER falls through and produces nothing
    assign is_branch = ret_valid_q && ((itype_q == ITYPE_BRANCH_TAKEN) ||
                                       (itype_q == ITYPE_BRANCH_NOT_TAKEN));
    assign is_req    = ret_valid_q && ((itype_q == ITYPE_JUMP_UNINF) ||
                                       (itype_q == ITYPE_EXCEPTION));

    // second stage drives the strobes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            branch_valid_o <= 1'b0;
            packet_req_o   <= 1'b0;
        end else begin
            branch_valid_o <= is_branch;
            packet_req_o   <= is_req;
        end
        branch_taken_o <= (itype_q == ITYPE_BRANCH_TAKEN);
        // address only matters alongside a request
        if (is_req) begin
            req_addr_o <= iaddr_q;
        end
    end

    // one retirement per cycle, so a branch and a request never coincide
    a_branch_xor_req: assert property (
        @(posedge clk) disable iff (reset_i)
        !(branch_valid_o && packet_req_o)
    ) else $error("branch strobe and packet request high together");

endmodule

/* hw/branch_map.sv */
/*
 * branch map
 * collects taken/not-taken outcomes into a bit map with a running count
 */
module branch_map
    import trace_params_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic                        branch_taken_i,
    input  logic                        flush_i,
    output logic [BRANCH_MAP_LEN-1:0]   map_o,
    output logic [BRANCH_COUNT_LEN-1:0] branches_o,
    output logic                        is_full_o,
    output logic                        is_empty_o
);

    logic [BRANCH_MAP_LEN-1:0]   map_q;
    logic [BRANCH_COUNT_LEN-1:0] branches_q;

    logic [BRANCH_MAP_LEN-1:0]   map_d;
    logic [BRANCH_COUNT_LEN-1:0] branches_d;

    // flush first, then the new outcome lands on top of whatever is left,
    // so flush plus branch gives a map with only bit 0 and count 1
    always_comb begin
        map_d      = map_q;
        branches_d = branches_q;

        if (flush_i) begin
            map_d      = '0;
            branches_d = '0;
        end

        if (valid_i) begin
            map_d[branches_d] = branch_taken_i;
            branches_d        = branches_d + 1'b1;
        end
    end

    // outcome bits and count
    always_ff @(posedge clk) begin
        if (reset_i) begin
            map_q      <= '0;
            branches_q <= '0;
        end else begin
            map_q      <= map_d;
            branches_q <= branches_d;
        end
    end

    assign map_o      = map_q;
    assign branches_o = branches_q;

    // full at 31 outcomes
    assign is_full_o  = (branches_q == BRANCH_COUNT_LEN'(BRANCH_MAP_LEN));
    assign is_empty_o = (branches_q == '0);

    // next count before it wraps in the five-bit register
    a_count_in_range: assert property (
        @(posedge clk) disable iff (reset_i)
        (flush_i ? 32'(valid_i) : 32'(branches_q) + 32'(valid_i)) <= BRANCH_MAP_LEN
    ) else $error("branch count beyond map length");

    // the emitter must drain a full map before another outcome arrives
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset_i)
        (valid_i && is_full_o) |-> flush_i
    ) else $error("branch written into a full map without flush");

endmodule

/* hw/branch_packet_emitter.sv */
/*
 * branch packet emitter
 * emits a trace packet on a request or a full map and flushes the map
 */
module branch_packet_emitter
    import trace_params_pkg::*, trace_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        packet_req_i,
    input  logic [IADDR_LEN-1:0]        req_addr_i,
    input  logic [BRANCH_MAP_LEN-1:0]   map_i,
    input  logic [BRANCH_COUNT_LEN-1:0] branches_i,
    input  logic                        is_full_i,
    input  logic                        is_empty_i,
    output logic                        flush_o,
    output logic                        packet_valid_o,
    output pkt_fmt_e                    packet_fmt_o,
    output logic [BRANCH_MAP_LEN-1:0]   packet_map_o,
    output logic [BRANCH_COUNT_LEN-1:0] packet_count_o,
    output logic [IADDR_LEN-1:0]        packet_addr_o
);

    logic emit;

    // next packet fields
    pkt_fmt_e                    fmt_d;
    logic [BRANCH_MAP_LEN-1:0]   map_d;
    logic [BRANCH_COUNT_LEN-1:0] count_d;
    logic [IADDR_LEN-1:0]        addr_d;

    assign emit = packet_req_i || is_full_i;

    // map starts over in the same cycle the packet is captured
    assign flush_o = emit;

    // a request wins over a full map and still carries the map along
    always_comb begin
        fmt_d   = FMT_BRANCH_FULL;
        map_d   = map_i;
        count_d = branches_i;
        addr_d  = '0;

        if (packet_req_i) begin
            addr_d = req_addr_i;
            if (is_empty_i) begin
                fmt_d   = FMT_ADDR_ONLY;
                map_d   = '0;
                count_d = '0;
            end else begin
                fmt_d = FMT_BRANCH_ADDR;
            end
        end
    end

    // fields hold until the next packet
    always_ff @(posedge clk) begin
        if (reset_i) begin
            packet_valid_o <= 1'b0;
            packet_fmt_o   <= FMT_BRANCH_FULL;
            packet_map_o   <= '0;
            packet_count_o <= '0;
            packet_addr_o  <= '0;
        end else begin
            packet_valid_o <= emit;
            if (emit) begin
                packet_fmt_o   <= fmt_d;
                packet_map_o   <= map_d;
                packet_count_o <= count_d;
                packet_addr_o  <= addr_d;
            end
        end
    end

    // a second packet in a row needs a new request or a freshly full map
    a_back_to_back: assert property (
        @(posedge clk) disable iff (reset_i)
        (packet_valid_o && $past(packet_valid_o)) |->
            ($past(packet_req_i) || ($past(is_full_i) && !$past(is_full_i, 2)))
    ) else $error("consecutive packets without a trigger for each");

endmodule

/* hw/branch_trace_top.sv */
/*
 * branch trace top
 * classifier feeds the branch map, the emitter drains it into packets
 */
module branch_trace_top
    import trace_params_pkg::*, trace_types_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        retire_valid_i,
    input  itype_e                      itype_i,
    input  logic [IADDR_LEN-1:0]        iaddr_i,
    output logic                        packet_valid_o,
    output pkt_fmt_e                    packet_fmt_o,
    output logic [BRANCH_MAP_LEN-1:0]   packet_map_o,
    output logic [BRANCH_COUNT_LEN-1:0] packet_count_o,
    output logic [IADDR_LEN-1:0]        packet_addr_o
);

    // classifier to map
    logic branch_valid;
    logic branch_taken;

    // classifier to emitter
    logic                 packet_req;
    logic [IADDR_LEN-1:0] req_addr;

    // map state seen by the emitter
    logic [BRANCH_MAP_LEN-1:0]   map;
    logic [BRANCH_COUNT_LEN-1:0] branches;
    logic                        is_full;
    logic                        is_empty;

    logic flush;

    instr_classifier u_classifier (
        .clk            (clk),
        .reset_i        (reset_i),
        .retire_valid_i (retire_valid_i),
        .itype_i        (itype_i),
        .iaddr_i        (iaddr_i),
        .branch_valid_o (branch_valid),
        .branch_taken_o (branch_taken),
        .packet_req_o   (packet_req),
        .req_addr_o     (req_addr)
    );

    branch_map u_branch_map (
        .clk            (clk),
        .reset_i        (reset_i),
        .valid_i        (branch_valid),
        .branch_taken_i (branch_taken),
        .flush_i        (flush),
        .map_o          (map),
        .branches_o     (branches),
        .is_full_o      (is_full),
        .is_empty_o     (is_empty)
    );

    branch_packet_emitter u_emitter (
        .clk            (clk),
        .reset_i        (reset_i),
        .packet_req_i   (packet_req),
        .req_addr_i     (req_addr),
        .map_i          (map),
        .branches_i     (branches),
        .is_full_i      (is_full),
        .is_empty_i     (is_empty),
        .flush_o        (flush),
        .packet_valid_o (packet_valid_o),
        .packet_fmt_o   (packet_fmt_o),
        .packet_map_o   (packet_map_o),
        .packet_count_o (packet_count_o),
        .packet_addr_o  (packet_addr_o)
    );

endmodule

/* verification/tb_branch_trace.sv */
/*
 * testbench for the branch trace encoder
 * replays a per-cycle retirement trace and checks every packet field
 */
module tb_branch_trace
    import trace_params_pkg::*, trace_types_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    // from the drive point to just before the next rising edge
    localparam int SAMPLE_DELAY = 80;
    localparam int RESET_CYCLES = 10;

    // hex words per trace line
    localparam int FIELDS         = 8;
    localparam int MAX_LINES      = 128;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + MAX_LINES + 20;

    // marks trace slots that the file did not fill
    localparam logic [31:0] EMPTY_WORD = 32'hffff_ffff;

    logic                        clk;
    logic                        reset_i;
    logic                        retire_valid_i;
    itype_e                      itype_i;
    logic [IADDR_LEN-1:0]        iaddr_i;
    logic                        packet_valid_o;
    pkt_fmt_e                    packet_fmt_o;
    logic [BRANCH_MAP_LEN-1:0]   packet_map_o;
    logic [BRANCH_COUNT_LEN-1:0] packet_count_o;
    logic [IADDR_LEN-1:0]        packet_addr_o;

    logic [31:0] trace_mem [0:FIELDS*MAX_LINES-1];

    int errors;
    int checks;
    int lines_run;

    branch_trace_top dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .retire_valid_i (retire_valid_i),
        .itype_i        (itype_i),
        .iaddr_i        (iaddr_i),
        .packet_valid_o (packet_valid_o),
        .packet_fmt_o   (packet_fmt_o),
        .packet_map_o   (packet_map_o),
        .packet_count_o (packet_count_o),
        .packet_addr_o  (packet_addr_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
        end
    endtask

    // first word of a line is retire_valid, so only 0 or 1 is a real line
    function automatic bit line_present(input int line);
        logic [31:0] flag;
        flag = trace_mem[line * FIELDS];
        return (flag == 32'd0) || (flag == 32'd1);
    endfunction

    task automatic drive_line(input int line);
        int base;
        base = line * FIELDS;
        retire_valid_i = trace_mem[base][0];
        itype_i        = itype_e'(trace_mem[base + 1][2:0]);
        iaddr_i        = trace_mem[base + 2];
    endtask

    // fields are checked every cycle since they hold between packets
    task automatic compare_line(input int line);
        int base;
        base = line * FIELDS;
        check_value("packet_valid_o", 32'(packet_valid_o), trace_mem[base + 3]);
        check_value("packet_fmt_o", 32'(packet_fmt_o), trace_mem[base + 4]);
        check_value("packet_map_o", 32'(packet_map_o), trace_mem[base + 5]);
        check_value("packet_count_o", 32'(packet_count_o), trace_mem[base + 6]);
        check_value("packet_addr_o", 32'(packet_addr_o), trace_mem[base + 7]);
    endtask

    initial begin
        int  line;
        bit  done;

        errors    = 0;
        checks    = 0;
        lines_run = 0;

        reset_i        = 1'b1;
        retire_valid_i = 1'b0;
        itype_i        = ITYPE_OTHER;
        iaddr_i        = '0;

        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            trace_mem[i] = EMPTY_WORD;
        end
        $readmemh("verification/branch_trace.txt", trace_mem);
        if (!line_present(0)) begin
            $display("trace file verification/branch_trace.txt is missing or has no lines");
            errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_i = 1'b0;

        // line k is driven after edge k and sampled before edge k+1
        line = 0;
        done = (errors != 0);
        while (!done) begin
            drive_line(line);
            #SAMPLE_DELAY;
            compare_line(line);
            lines_run++;
            line++;
            if (line >= MAX_LINES || !line_present(line)) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end

        $display("lines: %0d checks: %0d errors: %0d", lines_run, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog on the whole replay
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: trace replay did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("lines: %0d checks: %0d errors: %0d", lines_run, checks, errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* verification/branch_trace.txt */
// columns: retire_valid itype iaddr, then expected packet_valid packet_fmt
// packet_map packet_count packet_addr; one line per cycle, all hex
0 0 00000000 0 0 00000000 00 00000000
1 0 00001000 0 0 00000000 00 00000000
1 3 00001004 0 0 00000000 00 00000000
0 0 00000000 0 0 00000000 00 00000000
0 0 00000000 0 0 00000000 00 00000000
0 0 00000000 1 2 00000000 00 00001004
1 1 00001010 0 2 00000000 00 00001004
1 2 00001014 0 2 00000000 00 00001004
1 1 00001018 0 2 00000000 00 00001004
1 1 0000101c 0 2 00000000 00 00001004
1 0 00001020 0 2 00000000 00 00001004
1 3 00001024 0 2 00000000 00 00001004
1 1 00001028 0 2 00000000 00 00001004
0 0 00000000 0 2 00000000 00 00001004
0 0 00000000 1 1 0000000d 04 00001024
1 4 00002000 0 1 0000000d 04 00001024
0 0 00000000 0 1 0000000d 04 00001024
0 0 00000000 0 1 0000000d 04 00001024
0 0 00000000 1 1 00000001 01 00002000
1 1 00003000 0 1 00000001 01 00002000
1 1 00003004 0 1 00000001 01 00002000
1 2 00003008 0 1 00000001 01 00002000
1 1 0000300c 0 1 00000001 01 00002000
1 1 00003010 0 1 00000001 01 00002000
1 2 00003014 0 1 00000001 01 00002000
1 1 00003018 0 1 00000001 01 00002000
1 1 0000301c 0 1 00000001 01 00002000
1 2 00003020 0 1 00000001 01 00002000
1 1 00003024 0 1 00000001 01 00002000
1 1 00003028 0 1 00000001 01 00002000
1 2 0000302c 0 1 00000001 01 00002000
1 1 00003030 0 1 00000001 01 00002000
1 1 00003034 0 1 00000001 01 00002000
1 2 00003038 0 1 00000001 01 00002000
1 1 0000303c 0 1 00000001 01 00002000
1 1 00003040 0 1 00000001 01 00002000
1 2 00003044 0 1 00000001 01 00002000
1 1 00003048 0 1 00000001 01 00002000
1 1 0000304c 0 1 00000001 01 00002000
1 2 00003050 0 1 00000001 01 00002000
1 1 00003054 0 1 00000001 01 00002000
1 1 00003058 0 1 00000001 01 00002000
1 2 0000305c 0 1 00000001 01 00002000
1 1 00003060 0 1 00000001 01 00002000
1 1 00003064 0 1 00000001 01 00002000
1 2 00003068 0 1 00000001 01 00002000
1 1 0000306c 0 1 00000001 01 00002000
1 1 00003070 0 1 00000001 01 00002000
1 2 00003074 0 1 00000001 01 00002000
1 1 00003078 0 1 00000001 01 00002000
1 1 0000307c 0 1 00000001 01 00002000
1 2 00003080 0 1 00000001 01 00002000
1 3 00004000 0 1 00000001 01 00002000
0 0 00000000 1 0 5b6db6db 1f 00000000
1 0 00004004 0 0 5b6db6db 1f 00000000
0 0 00000000 1 1 00000001 02 00004000
0 0 00000000 0 1 00000001 02 00004000

/* src.f */
hw/trace_params_pkg.sv
hw/trace_types_pkg.sv
hw/instr_classifier.sv
hw/branch_map.sv
hw/branch_packet_emitter.sv
hw/branch_trace_top.sv
verification/tb_branch_trace.sv

/* Makefile */
# Verilator build and run for the branch trace encoder testbench

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_branch_trace
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
